// ==== src/icache_pkg.sv ====
//////////////////////////////
// cache geometry is fixed: 8 ways, 128 sets, 16 byte lines
// address fields assume a 32 bit fetch address
//////////////////////////////
package icache_pkg;

    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 128;

    // fetch address split
    localparam int TAG_W    = 21;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 4;

    localparam int LINE_W = 128;    // one full line returned per fetch

    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [2:0]         way_sel_t;    // binary way number

endpackage

// ==== src/icache_bus_pkg.sv ====
//////////////////////////////
// memory side carries two 64 bit beats per line only
// register map is four words, no byte enables
//////////////////////////////
package icache_bus_pkg;

    localparam int ADDR_W = 32;

    // refill burst shape
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 2;
    localparam int BEAT_IDX_W     = $clog2(BEATS_PER_LINE);

    // register port
    localparam int CSR_ADDR_W = 2;

    localparam logic [CSR_ADDR_W-1:0] REG_CTRL   = 2'd0;
    localparam logic [CSR_ADDR_W-1:0] REG_STATUS = 2'd1;
    localparam logic [CSR_ADDR_W-1:0] REG_HITS   = 2'd2;
    localparam logic [CSR_ADDR_W-1:0] REG_MISSES = 2'd3;

    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_FLUSH_BIT  = 1;
    localparam int STATUS_BUSY_BIT = 0;

    typedef logic [31:0] csr_word_t;

endpackage

// ==== src/icache_ifs.sv ====
`timescale 1ns/1ns
//////////////////////////////
// both links use a four-phase req/ack handshake
// a new req may rise only after ack has fallen
//////////////////////////////

// controller to refill engine
interface refill_if import icache_pkg::*, icache_bus_pkg::*; ();

    logic              fill_req;
    logic [ADDR_W-1:0] line_addr;    // line aligned, held while fill_req is high
    line_t             line;         // held while fill_ack is high
    logic              fill_ack;

    modport ctrl (
        output fill_req,
        output line_addr,
        input  line,
        input  fill_ack
    );

    modport refill (
        input  fill_req,
        input  line_addr,
        output line,
        output fill_ack
    );

endinterface

// configuration block to controller
interface cache_cfg_if ();

    logic enable;
    logic flush_req;
    logic flush_ack;
    logic hit_pulse;     // one cycle per hitting fetch
    logic miss_pulse;    // one cycle per missing or bypassed fetch

    modport cfg (
        output enable,
        output flush_req,
        input  flush_ack,
        input  hit_pulse,
        input  miss_pulse
    );

    modport ctrl (
        input  enable,
        input  flush_req,
        output flush_ack,
        output hit_pulse,
        output miss_pulse
    );

endinterface

// ==== src/way_ram.sv ====
`timescale 1ns/1ns
//////////////////////////////
// behavioural stand-in for one way of SRAM
// read data one cycle after the address, old data on a write
//////////////////////////////
module way_ram import icache_pkg::*; #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  index_t addr_i,
    input  logic   we_i,
    input  entry_t wdata_i,
    output entry_t rdata_o
);

    entry_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];    // registered read
    end

endmodule

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ns
//////////////////////////////
// one fetch in flight; a hit answers two edges after acceptance
// enable is sampled once per fetch, at acceptance
// flush is served only when idle with no fetch pending
//////////////////////////////
module icache_ctrl import icache_pkg::*, icache_bus_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_valid_i,
    input  logic [ADDR_W-1:0]   fetch_addr_i,
    output logic                fetch_ready_o,
    output line_t               fetch_data_o,
    output index_t              tag_addr_o,
    output logic [NUM_WAYS-1:0] tag_we_o,
    output tag_t                tag_wdata_o,
    input  tag_t                tag_rdata_i [NUM_WAYS],
    output logic [NUM_WAYS-1:0] data_we_o,
    output line_t               data_wdata_o,
    input  line_t               data_rdata_i [NUM_WAYS],
    refill_if.ctrl              fill,
    cache_cfg_if.ctrl           cfg
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_RESPOND,
        S_FILL,
        S_FLUSH
    } state_t;

    state_t                            state_q;
    logic [ADDR_W-1:0]                 req_addr_q;
    logic                              use_cache_q;    // enable seen at acceptance
    line_t                             resp_line_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    way_sel_t                          rand_way_q;
    way_sel_t                          victim_q;
    logic                              fill_req_q;
    logic                              flush_ack_q;

    tag_t                req_tag;
    index_t              req_index;
    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit;
    way_sel_t            hit_way;
    way_sel_t            victim_way;
    logic [NUM_WAYS-1:0] way_we;

    assign req_tag   = req_addr_q[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr_q[OFFSET_W +: INDEX_W];

    // arrays see the incoming index while idle so lookup has data one edge later
    assign tag_addr_o = (state_q == S_IDLE) ? fetch_addr_i[OFFSET_W +: INDEX_W] : req_index;

    // tag compare, one-hot to binary, and victim choice
    always_comb begin
        hit_way    = '0;
        victim_way = rand_way_q;    // all valid: counter picks
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = use_cache_q && valid_q[req_index][w] && (tag_rdata_i[w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_sel_t'(w);
            end
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[req_index][w]) begin
                victim_way = way_sel_t'(w);    // lowest invalid wins
            end
        end
    end

    assign hit = |hit_vec;

    // victim written at the edge where fill_ack is seen
    always_comb begin
        way_we = '0;
        if (state_q == S_FILL && fill.fill_ack && use_cache_q) begin
            way_we[victim_q] = 1'b1;
        end
    end

    assign tag_we_o     = way_we;
    assign data_we_o    = way_we;
    assign tag_wdata_o  = req_tag;
    assign data_wdata_o = fill.line;

    assign fetch_ready_o  = (state_q == S_RESPOND);
    assign fetch_data_o   = resp_line_q;
    assign fill.fill_req  = fill_req_q;
    assign fill.line_addr = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign cfg.flush_ack  = flush_ack_q;
    assign cfg.hit_pulse  = (state_q == S_LOOKUP) && hit;
    assign cfg.miss_pulse = (state_q == S_LOOKUP) && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            rand_way_q <= '0;
        end else begin
            rand_way_q <= rand_way_q + 1'b1;    // free running
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_IDLE;
            fill_req_q  <= 1'b0;
            flush_ack_q <= 1'b0;
            use_cache_q <= 1'b0;
            valid_q     <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fetch_valid_i) begin
                        use_cache_q <= cfg.enable;
                        state_q     <= S_LOOKUP;
                    end else if (cfg.flush_req) begin
                        valid_q     <= '0;    // every set at once
                        flush_ack_q <= 1'b1;
                        state_q     <= S_FLUSH;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state_q <= S_RESPOND;
                    end else begin
                        fill_req_q <= 1'b1;
                        state_q    <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (fill.fill_ack) begin
                        fill_req_q <= 1'b0;
                        if (use_cache_q) begin
                            valid_q[req_index][victim_q] <= 1'b1;
                        end
                        state_q <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    state_q <= S_IDLE;
                end
                S_FLUSH: begin
                    if (!cfg.flush_req) begin
                        flush_ack_q <= 1'b0;
                        state_q     <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // request address, response line, chosen victim
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && fetch_valid_i) begin
            req_addr_q <= fetch_addr_i;
        end
        if (state_q == S_LOOKUP) begin
            resp_line_q <= data_rdata_i[hit_way];
            victim_q    <= victim_way;
        end
        if (state_q == S_FILL && fill.fill_ack) begin
            resp_line_q <= fill.line;
        end
    end

endmodule

// ==== src/refill_master.sv ====
`timescale 1ns/1ns
//////////////////////////////
// two-beat bursts only, no error responses
// every valid beat is taken, beat 0 lands in the low half
//////////////////////////////
module refill_master import icache_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    output logic              mem_req_valid_o,
    output logic [ADDR_W-1:0] mem_req_addr_o,
    input  logic              mem_req_ready_i,
    input  logic              mem_rvalid_i,
    input  logic [BEAT_W-1:0] mem_rdata_i,
    input  logic              mem_rlast_i,
    refill_if.refill          fill
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA,
        R_ACK
    } rstate_t;

    rstate_t                               state_q;
    logic [BEAT_IDX_W-1:0]                 beat_cnt_q;
    logic [BEATS_PER_LINE-1:0][BEAT_W-1:0] beats_q;
    logic                                  fill_ack_q;

    assign fill.line     = beats_q;
    assign fill.fill_ack = fill_ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= R_IDLE;
            mem_req_valid_o <= 1'b0;
            fill_ack_q      <= 1'b0;
            beat_cnt_q      <= '0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    if (fill.fill_req) begin
                        mem_req_valid_o <= 1'b1;
                        beat_cnt_q      <= '0;
                        state_q         <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (mem_req_ready_i) begin    // address phase done
                        mem_req_valid_o <= 1'b0;
                        state_q         <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (mem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (mem_rlast_i) begin
                            fill_ack_q <= 1'b1;
                            state_q    <= R_ACK;
                        end
                    end
                end
                R_ACK: begin
                    if (!fill.fill_req) begin    // line held until req drops
                        fill_ack_q <= 1'b0;
                        state_q    <= R_IDLE;
                    end
                end
                default: begin
                    state_q <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == R_IDLE && fill.fill_req) begin
            mem_req_addr_o <= fill.line_addr;
        end
        if (state_q == R_DATA && mem_rvalid_i) begin
            beats_q[beat_cnt_q] <= mem_rdata_i;
        end
    end

endmodule

// ==== src/icache_cfg_regs.sv ====
`timescale 1ns/1ns
//////////////////////////////
// reads are combinational, writes land on the next edge
// counters saturate and are read only
//////////////////////////////
module icache_cfg_regs import icache_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  csr_wr_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  csr_word_t             csr_wdata_i,
    output csr_word_t             csr_rdata_o,
    cache_cfg_if.cfg              cfg
);

    logic      enable_q;
    logic      flush_req_q;
    logic      busy;
    csr_word_t hits_q;
    csr_word_t misses_q;

    assign busy          = flush_req_q || cfg.flush_ack;    // until ack falls
    assign cfg.enable    = enable_q;
    assign cfg.flush_req = flush_req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q    <= 1'b1;
            flush_req_q <= 1'b0;
            hits_q      <= '0;
            misses_q    <= '0;
        end else begin
            if (csr_wr_i && csr_addr_i == REG_CTRL) begin
                enable_q <= csr_wdata_i[CTRL_EN_BIT];
                if (csr_wdata_i[CTRL_FLUSH_BIT] && !busy) begin
                    flush_req_q <= 1'b1;
                end
            end
            if (flush_req_q && cfg.flush_ack) begin
                flush_req_q <= 1'b0;
            end
            if (cfg.hit_pulse && hits_q != '1) begin
                hits_q <= hits_q + 1'b1;
            end
            if (cfg.miss_pulse && misses_q != '1) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    always_comb begin
        csr_rdata_o = '0;
        case (csr_addr_i)
            REG_CTRL:   csr_rdata_o[CTRL_EN_BIT] = enable_q;
            REG_STATUS: csr_rdata_o[STATUS_BUSY_BIT] = busy;
            REG_HITS:   csr_rdata_o = hits_q;
            REG_MISSES: csr_rdata_o = misses_q;
            default:    csr_rdata_o = '0;
        endcase
    end

endmodule

// ==== src/icache_top.sv ====
`timescale 1ns/1ns
//////////////////////////////
// read-only fetch cache, 16 KiB, one fetch at a time
// memory must return exactly two beats per request
//////////////////////////////
module icache_top import icache_pkg::*, icache_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_valid_i,
    input  logic [ADDR_W-1:0]     fetch_addr_i,
    output logic                  fetch_ready_o,
    output line_t                 fetch_data_o,
    output logic                  mem_req_valid_o,
    output logic [ADDR_W-1:0]     mem_req_addr_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rvalid_i,
    input  logic [BEAT_W-1:0]     mem_rdata_i,
    input  logic                  mem_rlast_i,
    input  logic                  csr_wr_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  csr_word_t             csr_wdata_i,
    output csr_word_t             csr_rdata_o
);

    refill_if    rif ();
    cache_cfg_if cif ();

    index_t              ram_addr;    // shared by every way
    logic [NUM_WAYS-1:0] tag_we;
    logic [NUM_WAYS-1:0] data_we;
    tag_t                tag_wdata;
    line_t               data_wdata;
    tag_t                tag_rdata [NUM_WAYS];
    line_t               data_rdata [NUM_WAYS];

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid_i(fetch_valid_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_ready_o(fetch_ready_o),
        .fetch_data_o (fetch_data_o),
        .tag_addr_o   (ram_addr),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .tag_rdata_i  (tag_rdata),
        .data_we_o    (data_we),
        .data_wdata_o (data_wdata),
        .data_rdata_i (data_rdata),
        .fill         (rif.ctrl),
        .cfg          (cif.ctrl)
    );

    refill_master u_refill (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_addr_o (mem_req_addr_o),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_rlast_i    (mem_rlast_i),
        .fill           (rif.refill)
    );

    icache_cfg_regs u_cfg (
        .clk        (clk),
        .rst        (rst),
        .csr_wr_i   (csr_wr_i),
        .csr_addr_i (csr_addr_i),
        .csr_wdata_i(csr_wdata_i),
        .csr_rdata_o(csr_rdata_o),
        .cfg        (cif.cfg)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        way_ram #(.entry_t(tag_t)) u_tag_ram (
            .clk    (clk),
            .addr_i (ram_addr),
            .we_i   (tag_we[w]),
            .wdata_i(tag_wdata),
            .rdata_o(tag_rdata[w])
        );

        way_ram #(.entry_t(line_t)) u_data_ram (
            .clk    (clk),
            .addr_i (ram_addr),
            .we_i   (data_we[w]),
            .wdata_i(data_wdata),
            .rdata_o(data_rdata[w])
        );
    end

endmodule

// ==== dv/icache_properties.sv ====
`timescale 1ns/1ns
//////////////////////////////
// bound into icache_top, checks data, timing and handshakes
// expected line follows the memory model: beat k = {A, ~A + k}
// fail_cnt counts every failed assertion
//////////////////////////////
module icache_properties import icache_pkg::*, icache_bus_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              fetch_ready_i,
    input line_t             fetch_data_i,
    input logic [ADDR_W-1:0] fetch_addr_i,
    input logic              mem_req_valid_i,
    input logic              mem_req_ready_i,
    input logic [ADDR_W-1:0] mem_req_addr_i,
    input logic              fill_req_i,
    input logic              fill_ack_i
);

    int   fail_cnt = 0;
    logic fill_open_q;    // fill_req seen, no fill_ack yet

    function automatic line_t pattern_line(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        return {base, ~base + 32'd1, base, ~base};    // beat 1 above beat 0
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_open_q <= 1'b0;
        end else if (fill_ack_i) begin
            fill_open_q <= 1'b0;
        end else if (fill_req_i) begin
            fill_open_q <= 1'b1;
        end
    end

    a_fetch_data: assert property (@(posedge clk) disable iff (rst)
        fetch_ready_i |-> fetch_data_i == pattern_line(fetch_addr_i))
        else begin
            $error("Mismatch at %0t: line %h for address %h", $time, fetch_data_i, fetch_addr_i);
            fail_cnt++;
        end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i))
        else begin
            $error("memory request dropped or changed before it was accepted");
            fail_cnt++;
        end

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_ready_i |=> !fetch_ready_i)
        else begin
            $error("fetch_ready_o stayed high for more than one cycle");
            fail_cnt++;
        end

    a_fill_handshake: assert property (@(posedge clk) disable iff (rst)
        $rose(fill_req_i) |-> !fill_open_q && !fill_ack_i)
        else begin
            $error("fill_req rose again before fill_ack completed the handshake");
            fail_cnt++;
        end

endmodule

bind icache_top icache_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .fetch_ready_i  (fetch_ready_o),
    .fetch_data_i   (fetch_data_o),
    .fetch_addr_i   (fetch_addr_i),
    .mem_req_valid_i(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_req_addr_i (mem_req_addr_o),
    .fill_req_i     (rif.fill_req),
    .fill_ack_i     (rif.fill_ack)
);

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ns
//////////////////////////////
// inputs change 1 ns after the rising edge, 4 ns clock
// memory answers with random delay, beat k of line A is {A, ~A + k}
// data checks live in the bound assertions
//////////////////////////////
module icache_tb import icache_pkg::*, icache_bus_pkg::*; ();

    localparam int WAIT_CYCLES = 300;

    typedef enum int {
        EXP_MISS,
        EXP_HIT,
        EXP_ANY
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid_i;
    logic [ADDR_W-1:0]     fetch_addr_i;
    logic                  fetch_ready_o;
    line_t                 fetch_data_o;
    logic                  mem_req_valid_o;
    logic [ADDR_W-1:0]     mem_req_addr_o;
    logic                  mem_req_ready_i;
    logic                  mem_rvalid_i;
    logic [BEAT_W-1:0]     mem_rdata_i;
    logic                  mem_rlast_i;
    logic                  csr_wr_i;
    logic [CSR_ADDR_W-1:0] csr_addr_i;
    csr_word_t             csr_wdata_i;
    csr_word_t             csr_rdata_o;

    int    seed = 20;
    int    mem_reqs = 0;       // requests accepted by the memory model
    int    fetch_count = 0;
    int    exp_hits = 0;
    int    exp_misses = 0;
    int    errors = 0;
    int    test_errs = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    props_at_start = 0;
    string test_name;

    icache_top dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic write_csr(input logic [CSR_ADDR_W-1:0] addr, input csr_word_t data);
        csr_wr_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        @(posedge clk);
        #1;
        csr_wr_i = 1'b0;
    endtask

    task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr, output csr_word_t data);
        csr_addr_i = addr;
        #1;
        data = csr_rdata_o;    // combinational read
        @(posedge clk);
        #1;
    endtask

    // one memory burst, random acceptance delay and beat gaps
    task automatic serve_request;
        logic [ADDR_W-1:0] base;
        int                gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        base            = mem_req_addr_o;
        mem_req_ready_i = 1'b1;
        @(posedge clk);
        #1;
        mem_req_ready_i = 1'b0;
        mem_reqs++;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = {base, ~base + 32'(k)};
            mem_rlast_i  = (k == BEATS_PER_LINE - 1);
            @(posedge clk);
            #1;
            mem_rvalid_i = 1'b0;
            mem_rlast_i  = 1'b0;
        end
    endtask

    initial begin : memory_model
        mem_req_ready_i = 1'b0;
        mem_rvalid_i    = 1'b0;
        mem_rdata_i     = '0;
        mem_rlast_i     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req_valid_o === 1'b1) begin
                serve_request();
            end
        end
    end

    task automatic do_fetch(input logic [ADDR_W-1:0] addr, input expect_t kind);
        int cycles;
        int reqs_before;
        reqs_before   = mem_reqs;
        cycles        = 0;
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addr;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!fetch_ready_o && cycles < WAIT_CYCLES);
        if (!fetch_ready_o) begin
            abort_run($sformatf("Timeout: no fetch_ready_o for address %h", addr));
        end
        fetch_valid_i = 1'b0;    // address stays until the next fetch
        fetch_count++;
        if (kind == EXP_HIT || (kind == EXP_ANY && mem_reqs == reqs_before)) begin
            exp_hits++;
        end else begin
            exp_misses++;
        end
        if (kind == EXP_HIT && (mem_reqs != reqs_before || cycles != 2)) begin
            report_mismatch($sformatf("hit on %h took %0d cycles, %0d memory requests",
                                      addr, cycles, mem_reqs - reqs_before));
        end
        if (kind == EXP_MISS && mem_reqs != reqs_before + 1) begin
            report_mismatch($sformatf("miss on %h made %0d memory requests",
                                      addr, mem_reqs - reqs_before));
        end
        @(posedge clk);    // valid low for one cycle
        #1;
    endtask

    task automatic check_counters;
        csr_word_t hits;
        csr_word_t misses;
        read_csr(REG_HITS, hits);
        read_csr(REG_MISSES, misses);
        if (hits != exp_hits) begin
            report_mismatch($sformatf("hit counter %0d, expected %0d", hits, exp_hits));
        end
        if (misses != exp_misses) begin
            report_mismatch($sformatf("miss counter %0d, expected %0d", misses, exp_misses));
        end
        if (hits + misses != fetch_count) begin
            report_mismatch($sformatf("hits plus misses %0d, fetches %0d",
                                      hits + misses, fetch_count));
        end
    endtask

    task automatic check_ctrl_reg(input csr_word_t expected);
        csr_word_t ctrl_word;
        read_csr(REG_CTRL, ctrl_word);
        if (ctrl_word != expected) begin
            report_mismatch($sformatf("REG_CTRL reads %h, expected %h", ctrl_word, expected));
        end
    endtask

    task automatic flush_cache;
        csr_word_t status;
        int        cycles;
        write_csr(REG_CTRL, 32'h3);    // keep enable, set flush
        cycles = 0;
        do begin
            read_csr(REG_STATUS, status);
            cycles++;
        end while (status[STATUS_BUSY_BIT] && cycles < WAIT_CYCLES);
        if (status[STATUS_BUSY_BIT]) begin
            abort_run("Timeout: flush never finished, REG_STATUS stayed busy");
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_errs      = 0;
        props_at_start = dut.u_props.fail_cnt;
    endtask

    task automatic finish_test;
        int prop_fails;
        prop_fails = dut.u_props.fail_cnt - props_at_start;
        tests_run++;
        if (test_errs == 0 && prop_fails == 0) begin
            $display("[%0t] test %s: ok", $time, test_name);
        end else begin
            tests_failed++;
            $display("[%0t] test %s: %0d mismatches, %0d assertion failures",
                     $time, test_name, test_errs, prop_fails);
        end
    endtask

    initial begin : main
        logic [ADDR_W-1:0] addr;
        rst           = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        csr_wr_i      = 1'b0;
        csr_addr_i    = '0;
        csr_wdata_i   = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("cold_miss_hit");
        do_fetch(32'h0000_1010, EXP_MISS);
        do_fetch(32'h0000_1010, EXP_HIT);
        check_counters();
        finish_test();

        start_test("set_capacity");
        for (int i = 0; i < NUM_WAYS; i++) begin
            do_fetch({21'(32 + i), 7'd5, 4'h0}, EXP_MISS);
        end
        check_counters();
        for (int i = 0; i < NUM_WAYS; i++) begin
            do_fetch({21'(32 + i), 7'd5, 4'h4}, EXP_HIT);
        end
        check_counters();
        finish_test();

        start_test("flush");
        flush_cache();
        do_fetch(32'h0000_1010, EXP_MISS);
        do_fetch(32'h0000_1018, EXP_HIT);
        check_counters();
        finish_test();

        start_test("disable_bypass");
        write_csr(REG_CTRL, 32'h0);
        check_ctrl_reg(32'h0);
        do_fetch(32'h0070_0098, EXP_MISS);
        do_fetch(32'h0070_0098, EXP_MISS);
        do_fetch(32'h0000_1010, EXP_MISS);    // cached, still bypassed
        write_csr(REG_CTRL, 32'h1);
        check_ctrl_reg(32'h1);
        do_fetch(32'h0070_0098, EXP_MISS);    // bypass left no fill
        do_fetch(32'h0000_1010, EXP_HIT);
        check_counters();
        finish_test();

        start_test("random_traffic");
        for (int i = 0; i < 48; i++) begin
            addr = {17'h00a5c, 4'($random(seed)), 7'(20 + $unsigned($random(seed)) % 2),
                    4'($random(seed))};
            do_fetch(addr, EXP_ANY);
        end
        check_counters();
        finish_test();

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, dut.u_props.fail_cnt);
        if (tests_failed == 0 && dut.u_props.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== icache_sys.f ====
src/icache_pkg.sv
src/icache_bus_pkg.sv
src/icache_ifs.sv
src/way_ram.sv
src/icache_ctrl.sv
src/refill_master.sv
src/icache_cfg_regs.sv
src/icache_top.sv
dv/icache_properties.sv
dv/icache_tb.sv
